// ==== vdp_pkg.sv ====
// Standard MSX2 mode subset only, register numbers above R19 and the extended palette are absent
package vdp_pkg;

  // CPU port selector, the low two address bits of ports 98h to 9Bh
  typedef enum logic [1:0] {
    port_vram     = 2'd0,
    port_ctrl     = 2'd1,
    port_palette  = 2'd2,
    port_indirect = 2'd3
  } vdp_port_e;

  // Decoded screen mode
  typedef enum logic [3:0] {
    graphic1  = 4'd0,
    graphic2  = 4'd1,
    graphic3  = 4'd2,
    graphic4  = 4'd3,
    graphic5  = 4'd4,
    graphic6  = 4'd5,
    graphic7  = 4'd6,
    text1     = 4'd7,
    text2     = 4'd8,
    multi     = 4'd9,
    text1q    = 4'd10,
    multiq    = 4'd11,
    mode_none = 4'd15   // Any other M5..M1 pattern
  } vdp_mode_e;

  localparam int REG_NUM_W    = 6;
  localparam int STATUS_NUM_W = 4;
  localparam int PAL_INDEX_W  = 8;

  localparam logic [REG_NUM_W-1:0] R_MODE0       = 6'd0;
  localparam logic [REG_NUM_W-1:0] R_MODE1       = 6'd1;
  localparam logic [REG_NUM_W-1:0] R_FRAME_COL   = 6'd7;
  localparam logic [REG_NUM_W-1:0] R_SPRITE_CTRL = 6'd8;
  localparam logic [REG_NUM_W-1:0] R_FORMAT      = 6'd9;
  localparam logic [REG_NUM_W-1:0] R_STATUS_SEL  = 6'd15;
  localparam logic [REG_NUM_W-1:0] R_PAL_INDEX   = 6'd16;
  localparam logic [REG_NUM_W-1:0] R_INDIRECT    = 6'd17;
  localparam logic [REG_NUM_W-1:0] R_HINT_LINE   = 6'd19;

  localparam logic [4:0] VDP_ID_V9958 = 5'd2;   // S#1 chip code

  // Power-on colours, 3 bits per channel in the top of each byte
  localparam logic [7:0] PAL_INIT_R [16] = '{8'h00, 8'h00, 8'h20, 8'h60, 8'h20, 8'h40, 8'hA0, 8'h40,
                                             8'hE0, 8'hE0, 8'hC0, 8'hC0, 8'h20, 8'hC0, 8'hA0, 8'hE0};
  localparam logic [7:0] PAL_INIT_G [16] = '{8'h00, 8'h00, 8'hC0, 8'hE0, 8'h20, 8'h60, 8'h20, 8'hC0,
                                             8'h20, 8'h60, 8'hC0, 8'hC0, 8'h80, 8'h40, 8'hA0, 8'hE0};
  localparam logic [7:0] PAL_INIT_B [16] = '{8'h00, 8'h00, 8'h20, 8'h60, 8'hE0, 8'hE0, 8'h20, 8'hE0,
                                             8'h20, 8'h60, 8'h20, 8'h80, 8'h20, 8'hA0, 8'hA0, 8'hE0};

endpackage

// ==== vdp_reg_bus_if.sv ====
// Strobes are one clock wide and appear in the cycle after the CPU request that caused them
`timescale 1ns/100ps

interface vdp_reg_bus_if;

  logic                          reg_wr;     // Register write strobe
  logic [vdp_pkg::REG_NUM_W-1:0] reg_num;
  logic [7:0]                    reg_data;
  logic                          status_rd;  // CPU read of the control port

  modport decoder (
    output reg_wr,
    output reg_num,
    output reg_data,
    output status_rd
  );

  modport listener (
    input reg_wr,
    input reg_num,
    input reg_data,
    input status_rd
  );

endinterface

// ==== vdp_port_decoder.sv ====
// VRAM data and address bytes are swallowed, and the CPU side never waits on ack
`timescale 1ns/100ps

module vdp_port_decoder (
  input  logic               reset,     // Clock
  input  logic               clk21m,    // Asynchronous reset, active high
  input  logic               req,
  input  logic               wrt,
  input  vdp_pkg::vdp_port_e port,
  input  logic [7:0]         dbo,
  output logic               ack,
  output logic               pal_wr,
  output logic [7:0]         pal_data,
  vdp_reg_bus_if.decoder     bus
);

  import vdp_pkg::*;

  logic                 first_byte;   // Control port waits for its data byte
  logic [7:0]           p1_data;      // Buffered first byte
  logic [REG_NUM_W-1:0] r17_num;      // Indirect target register
  logic                 r17_inc;      // Auto-increment after each indirect write

  // --------------------------------------------------------------------------
  // CPU request decode
  // --------------------------------------------------------------------------
  always_ff @(posedge reset or posedge clk21m) begin
    if (clk21m) begin
      ack           <= 1'b0;
      pal_wr        <= 1'b0;
      pal_data      <= 8'h00;
      first_byte    <= 1'b1;
      p1_data       <= 8'h00;
      r17_num       <= '0;
      r17_inc       <= 1'b0;
      bus.reg_wr    <= 1'b0;
      bus.reg_num   <= '0;
      bus.reg_data  <= 8'h00;
      bus.status_rd <= 1'b0;
    end else begin
      ack           <= req;
      pal_wr        <= 1'b0;
      bus.reg_wr    <= 1'b0;
      bus.status_rd <= 1'b0;

      if (req && !wrt) begin
        if (port == port_ctrl) begin
          first_byte    <= 1'b1;   // Status read restarts the byte pairing
          bus.status_rd <= 1'b1;
        end
      end else if (req && wrt) begin
        case (port)
          port_ctrl: begin
            if (first_byte) begin
              first_byte <= 1'b0;
              p1_data    <= dbo;
            end else begin
              first_byte <= 1'b1;
              // 1x selects a register, 0x would be a VRAM address
              if (dbo[7]) begin
                bus.reg_wr   <= 1'b1;
                bus.reg_num  <= dbo[REG_NUM_W-1:0];
                bus.reg_data <= p1_data;
              end
            end
          end
          port_palette: begin
            pal_wr   <= 1'b1;
            pal_data <= dbo;
          end
          port_indirect: begin
            bus.reg_num  <= r17_num;
            bus.reg_data <= dbo;
            bus.reg_wr   <= (r17_num != R_INDIRECT);   // R17 never targets itself
            if (r17_inc) begin
              r17_num <= r17_num + REG_NUM_W'(1);
            end
          end
          default: begin
            // VRAM data port, nothing behind it
          end
        endcase
      end

      // R17 follows our own strobe and wins over an increment in the same cycle
      if (bus.reg_wr && bus.reg_num == R_INDIRECT) begin
        r17_num <= bus.reg_data[REG_NUM_W-1:0];
        r17_inc <= ~bus.reg_data[7];
      end
    end
  end

endmodule

// ==== vdp_control_regs.sv ====
// Only R0, R1, R7, R8, R9, R15 and R19 are stored and mode bits take effect on an hsync edge
`timescale 1ns/100ps

module vdp_control_regs (
  input  logic                              reset,    // Clock
  input  logic                              clk21m,   // Asynchronous reset, active high
  input  logic                              hsync,
  output vdp_pkg::vdp_mode_e                display_mode,
  output logic                              disp_on,
  output logic                              hsync_int_en,
  output logic                              vsync_int_en,
  output logic                              sprite_size,
  output logic                              sprite_zoom,
  output logic                              sprite_off,
  output logic                              col0_on,
  output logic                              pal_mode,
  output logic                              y_dots,
  output logic [7:0]                        frame_col,
  output logic [7:0]                        hint_line,
  output logic [vdp_pkg::STATUS_NUM_W-1:0]  status_num,
  vdp_reg_bus_if.listener                   bus
);

  import vdp_pkg::*;

  logic [4:0] mode_pend;      // {M5, M4, M3, M2, M1} as last written
  logic       disp_on_pend;
  logic [4:0] mode_bits;      // Active copy

  // Register writes, numbers 32 and up never match a case item
  always_ff @(posedge reset or posedge clk21m) begin
    if (clk21m) begin
      mode_pend    <= 5'b00000;
      disp_on_pend <= 1'b0;
      hsync_int_en <= 1'b0;
      vsync_int_en <= 1'b0;
      sprite_size  <= 1'b0;
      sprite_zoom  <= 1'b0;
      sprite_off   <= 1'b0;
      col0_on      <= 1'b0;
      pal_mode     <= 1'b0;
      y_dots       <= 1'b0;
      frame_col    <= 8'h00;
      hint_line    <= 8'h00;
      status_num   <= '0;
    end else if (bus.reg_wr) begin
      case (bus.reg_num)
        R_MODE0: begin
          mode_pend[4:2] <= bus.reg_data[3:1];
          hsync_int_en   <= bus.reg_data[4];
        end
        R_MODE1: begin
          sprite_zoom  <= bus.reg_data[0];
          sprite_size  <= bus.reg_data[1];
          mode_pend[1] <= bus.reg_data[3];    // M2
          mode_pend[0] <= bus.reg_data[4];    // M1
          vsync_int_en <= bus.reg_data[5];
          disp_on_pend <= bus.reg_data[6];
        end
        R_FRAME_COL:   frame_col <= bus.reg_data;
        R_SPRITE_CTRL: begin
          sprite_off <= bus.reg_data[1];
          col0_on    <= bus.reg_data[5];
        end
        R_FORMAT: begin
          pal_mode <= bus.reg_data[1];
          y_dots   <= bus.reg_data[7];
        end
        R_STATUS_SEL:  status_num <= bus.reg_data[STATUS_NUM_W-1:0];
        R_HINT_LINE:   hint_line  <= bus.reg_data;
        default: begin
          // Not held in this block
        end
      endcase
    end
  end

  // Mode change lands between lines
  always_ff @(posedge reset or posedge clk21m) begin
    if (clk21m) begin
      mode_bits <= 5'b00000;
      disp_on   <= 1'b0;
    end else if (hsync) begin
      mode_bits <= mode_pend;
      disp_on   <= disp_on_pend;
    end
  end

  always_comb begin
    case (mode_bits)
      5'b00000: display_mode = graphic1;
      5'b00001: display_mode = text1;
      5'b00010: display_mode = multi;
      5'b00100: display_mode = graphic2;
      5'b00101: display_mode = text1q;
      5'b00110: display_mode = multiq;
      5'b01000: display_mode = graphic3;
      5'b01001: display_mode = text2;
      5'b01100: display_mode = graphic4;
      5'b10000: display_mode = graphic5;
      5'b10100: display_mode = graphic6;
      5'b11100: display_mode = graphic7;
      default:  display_mode = mode_none;
    endcase
  end

endmodule

// ==== vdp_status_read.sv ====
// Only S#0 to S#2 exist, sprite and command status bits read as zero and other numbers read FFh
`timescale 1ns/100ps

module vdp_status_read #(
  parameter logic [4:0] VDP_ID = vdp_pkg::VDP_ID_V9958
) (
  input  logic                             reset,     // Clock
  input  logic                             clk21m,    // Asynchronous reset, active high
  input  logic                             req,
  input  logic                             wrt,
  input  vdp_pkg::vdp_port_e               port,
  input  logic [vdp_pkg::STATUS_NUM_W-1:0] status_num,
  input  logic                             vsync_int_n,
  input  logic                             hsync_int_n,
  input  logic                             field,
  output logic [7:0]                       dbi,
  output logic                             clr_vsync_int,
  output logic                             clr_hsync_int,
  vdp_reg_bus_if.listener                  bus
);

  import vdp_pkg::*;

  logic [STATUS_NUM_W-1:0] rd_num;    // R15 at the last CPU read
  logic                    hint_wr;   // Write that drops the line interrupt

  always_ff @(posedge reset or posedge clk21m) begin
    if (clk21m) begin
      dbi     <= 8'h00;
      rd_num  <= '0;
      hint_wr <= 1'b0;
    end else begin
      hint_wr <= bus.reg_wr && (bus.reg_num == R_HINT_LINE ||
                                (bus.reg_num == R_MODE0 && bus.reg_data[4]));
      if (req && !wrt) begin
        rd_num <= status_num;
        if (port == port_ctrl) begin
          case (status_num)
            STATUS_NUM_W'(0): dbi <= {~vsync_int_n, 7'b0000000};
            STATUS_NUM_W'(1): dbi <= {2'b00, VDP_ID, ~hsync_int_n};
            STATUS_NUM_W'(2): dbi <= {4'b0000, 2'b11, field, 1'b0};
            default:          dbi <= 8'hFF;
          endcase
        end else begin
          dbi <= 8'hFF;   // VRAM, palette and indirect ports
        end
      end
    end
  end

  // Decoder strobe marks the cycle after a control port read
  assign clr_vsync_int = bus.status_rd && (rd_num == STATUS_NUM_W'(0));
  assign clr_hsync_int = (bus.status_rd && (rd_num == STATUS_NUM_W'(1))) || hint_wr;

endmodule

// ==== vdp_palette.sv ====
// Standard two-byte palette writes land at once with no dot-timing arbitration, R16 sets index 0 to 15
`timescale 1ns/100ps

module vdp_palette (
  input  logic                            reset,        // Clock
  input  logic                            clk21m,       // Asynchronous reset, active high
  input  logic                            pal_wr,
  input  logic [7:0]                      pal_data,
  input  logic [vdp_pkg::PAL_INDEX_W-1:0] palette_addr,
  output logic [7:0]                      palette_r,
  output logic [7:0]                      palette_g,
  output logic [7:0]                      palette_b,
  vdp_reg_bus_if.listener                 bus
);

  import vdp_pkg::*;

  localparam int NUM_ENTRIES = 2 ** PAL_INDEX_W;

  logic                   first_byte;   // Next byte carries red and blue
  logic [PAL_INDEX_W-1:0] index;
  logic [2:0]             red_q;
  logic [2:0]             blue_q;
  logic                   ram_we;
  logic [PAL_INDEX_W-1:0] ram_addr;
  logic [7:0]             wr_data [3];                // R, G, B
  logic [7:0]             ram     [3][NUM_ENTRIES];
  logic [7:0]             rd_data [3];

  function automatic logic [7:0] init_value(int ch, int entry);
    logic [7:0] value;
    value = 8'h00;
    if (entry < 16) begin
      case (ch)
        0:       value = PAL_INIT_R[entry[3:0]];
        1:       value = PAL_INIT_G[entry[3:0]];
        default: value = PAL_INIT_B[entry[3:0]];
      endcase
    end
    return value;
  endfunction

  // --------------------------------------------------------------------------
  // Byte assembly and index
  // --------------------------------------------------------------------------
  always_ff @(posedge reset or posedge clk21m) begin
    if (clk21m) begin
      first_byte <= 1'b1;
      index      <= '0;
      red_q      <= 3'b000;
      blue_q     <= 3'b000;
    end else if (bus.reg_wr && bus.reg_num == R_PAL_INDEX) begin
      index      <= PAL_INDEX_W'(bus.reg_data[3:0]);
      first_byte <= 1'b1;
    end else if (pal_wr) begin
      if (first_byte) begin
        red_q      <= pal_data[6:4];
        blue_q     <= pal_data[2:0];
        first_byte <= 1'b0;
      end else begin
        first_byte <= 1'b1;
        index      <= index + PAL_INDEX_W'(1);   // Wraps past 255
      end
    end
  end

  assign ram_we   = pal_wr && !first_byte;
  assign ram_addr = ram_we ? index : palette_addr;   // Write address takes the port

  assign wr_data[0] = {red_q, 5'b00000};
  assign wr_data[1] = {pal_data[2:0], 5'b00000};
  assign wr_data[2] = {blue_q, 5'b00000};

  // --------------------------------------------------------------------------
  // Colour RAMs
  // --------------------------------------------------------------------------
  always_ff @(posedge reset or posedge clk21m) begin
    if (clk21m) begin
      for (int ch = 0; ch < 3; ch++) begin
        for (int i = 0; i < NUM_ENTRIES; i++) begin
          ram[ch][i] <= init_value(ch, i);
        end
      end
    end else if (ram_we) begin
      for (int ch = 0; ch < 3; ch++) begin
        ram[ch][ram_addr] <= wr_data[ch];
      end
    end
  end

  always_ff @(posedge reset) begin
    for (int ch = 0; ch < 3; ch++) begin
      rd_data[ch] <= ram[ch][ram_addr];
    end
  end

  assign palette_r = rd_data[0];
  assign palette_g = rd_data[1];
  assign palette_b = rd_data[2];

endmodule

// ==== vdp_register_top.sv ====
// CPU register block only, port 0 reads FFh and VRAM, sprites and the command engine are absent
`timescale 1ns/100ps

module vdp_register_top #(
  parameter logic [4:0] VDP_ID = vdp_pkg::VDP_ID_V9958
) (
  input  logic                            reset,         // Clock
  input  logic                            clk21m,        // Asynchronous reset, active high
  input  logic                            req,
  output logic                            ack,
  input  logic                            wrt,
  input  vdp_pkg::vdp_port_e              port,
  input  logic [7:0]                      dbo,
  output logic [7:0]                      dbi,
  input  logic                            hsync,
  input  logic                            vsync_int_n,
  input  logic                            hsync_int_n,
  input  logic                            field,
  output logic                            clr_vsync_int,
  output logic                            clr_hsync_int,
  input  logic [vdp_pkg::PAL_INDEX_W-1:0] palette_addr,
  output logic [7:0]                      palette_r,
  output logic [7:0]                      palette_g,
  output logic [7:0]                      palette_b,
  output vdp_pkg::vdp_mode_e              display_mode,
  output logic                            disp_on,
  output logic                            hsync_int_en,
  output logic                            vsync_int_en,
  output logic                            sprite_size,
  output logic                            sprite_zoom,
  output logic                            sprite_off,
  output logic                            col0_on,
  output logic                            pal_mode,
  output logic                            y_dots,
  output logic [7:0]                      frame_col,
  output logic [7:0]                      hint_line
);

  import vdp_pkg::*;

  vdp_reg_bus_if reg_bus ();

  logic                    pal_wr;
  logic [7:0]              pal_data;
  logic [STATUS_NUM_W-1:0] status_num;   // R15

  vdp_port_decoder u_decoder (
    .reset(reset), .clk21m(clk21m), .req(req), .wrt(wrt), .port(port), .dbo(dbo),
    .ack(ack), .pal_wr(pal_wr), .pal_data(pal_data), .bus(reg_bus.decoder)
  );

  vdp_control_regs u_regs (
    .reset(reset), .clk21m(clk21m), .hsync(hsync), .display_mode(display_mode),
    .disp_on(disp_on), .hsync_int_en(hsync_int_en), .vsync_int_en(vsync_int_en),
    .sprite_size(sprite_size), .sprite_zoom(sprite_zoom), .sprite_off(sprite_off),
    .col0_on(col0_on), .pal_mode(pal_mode), .y_dots(y_dots), .frame_col(frame_col),
    .hint_line(hint_line), .status_num(status_num), .bus(reg_bus.listener)
  );

  vdp_status_read #(.VDP_ID(VDP_ID)) u_status (
    .reset(reset), .clk21m(clk21m), .req(req), .wrt(wrt), .port(port),
    .status_num(status_num), .vsync_int_n(vsync_int_n), .hsync_int_n(hsync_int_n),
    .field(field), .dbi(dbi), .clr_vsync_int(clr_vsync_int),
    .clr_hsync_int(clr_hsync_int), .bus(reg_bus.listener)
  );

  vdp_palette u_palette (
    .reset(reset), .clk21m(clk21m), .pal_wr(pal_wr), .pal_data(pal_data),
    .palette_addr(palette_addr), .palette_r(palette_r), .palette_g(palette_g),
    .palette_b(palette_b), .bus(reg_bus.listener)
  );

endmodule

// ==== tb_vdp_register.sv ====
// Random CPU traffic from seed 59 against a behavioural model; S#1 expects the default VDP_ID
`timescale 1ns/100ps

module tb_vdp_register;

  import vdp_pkg::*;

  localparam int CYCLE_LIMIT = 20000;   // About ten times the length of the test sequence
  localparam logic [5:0] HELD [9] = '{6'd0, 6'd1, 6'd7, 6'd8, 6'd9, 6'd15, 6'd16, 6'd17, 6'd19};

  logic       reset;          // Clock
  logic       clk21m;         // Reset, active high
  logic       req;
  logic       wrt;
  vdp_port_e  port;
  logic [7:0] dbo;
  logic       hsync;
  logic       vsync_int_n;
  logic       hsync_int_n;
  logic       field;
  logic [7:0] palette_addr;
  logic       ack;
  logic [7:0] dbi;
  logic       clr_vsync_int;
  logic       clr_hsync_int;
  logic [7:0] palette_r;
  logic [7:0] palette_g;
  logic [7:0] palette_b;
  vdp_mode_e  display_mode;
  logic       disp_on, hsync_int_en, vsync_int_en, sprite_size, sprite_zoom;
  logic       sprite_off, col0_on, pal_mode, y_dots;
  logic [7:0] frame_col;
  logic [7:0] hint_line;

  // Reference model state
  logic [7:0] r0, r1, r7, r8, r9, r19;   // Register images as written
  logic [3:0] r15;
  logic [4:0] mode_act;                  // {M5..M1} copied at hsync
  logic       disp_act;
  logic [5:0] ind_num;                   // R17 target
  logic       ind_inc;
  logic [7:0] pal_idx;
  logic       pal_first;
  logic [2:0] pal_red;
  logic [2:0] pal_blue;
  logic [7:0] shadow_r [256];
  logic [7:0] shadow_g [256];
  logic [7:0] shadow_b [256];
  int         errors = 0;
  int         cycles = 0;
  logic       req_q;

  vdp_register_top uut (.*);

  always #50 reset = ~reset;

  always @(posedge reset) begin
    req_q  <= req;
    cycles = cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles, the test sequence did not finish", cycles);
      $display("=== FAIL ===");
      $finish;
    end
  end

  // ack must follow req by one cycle
  always @(negedge reset) begin
    if (!clk21m) begin
      assert (ack === req_q) else begin
        errors++;
        $display("Error at %0t ns: ack = %b, expected %b", $time, ack, req_q);
      end
    end
  end

  // --------------------------------------------------------------------------
  // Model helpers
  // --------------------------------------------------------------------------
  function automatic logic [3:0] expected_mode(input logic [4:0] m);
    logic [3:0] mode;
    mode = mode_none;
    case (m[1:0])                          // M2, M1
      2'b01: begin
        case (m[4:2])
          3'b000:  mode = text1;
          3'b001:  mode = text1q;
          3'b010:  mode = text2;
          default: mode = mode_none;
        endcase
      end
      2'b10: begin
        case (m[4:2])
          3'b000:  mode = multi;
          3'b001:  mode = multiq;
          default: mode = mode_none;
        endcase
      end
      2'b00: begin
        case (m[4:2])                      // M5, M4, M3
          3'b000:  mode = graphic1;
          3'b001:  mode = graphic2;
          3'b010:  mode = graphic3;
          3'b011:  mode = graphic4;
          3'b100:  mode = graphic5;
          3'b101:  mode = graphic6;
          3'b111:  mode = graphic7;
          default: mode = mode_none;
        endcase
      end
      default: mode = mode_none;
    endcase
    return mode;
  endfunction

  function automatic logic [7:0] expected_status(input logic [3:0] num);
    logic [7:0] value;
    value = 8'hFF;
    if (num == 4'd0) begin
      value = 8'h00;
      value[7] = ~vsync_int_n;
    end else if (num == 4'd1) begin
      value = 8'h00;
      value[5:1] = VDP_ID_V9958;
      value[0] = ~hsync_int_n;
    end else if (num == 4'd2) begin
      value = 8'h0C;                       // Bits 3 and 2 always set
      value[1] = field;
    end
    return value;
  endfunction

  task automatic model_write(input logic [5:0] num, input logic [7:0] data);
    case (num)
      6'd0:  r0 = data;
      6'd1:  r1 = data;
      6'd7:  r7 = data;
      6'd8:  r8 = data;
      6'd9:  r9 = data;
      6'd15: r15 = data[3:0];
      6'd16: begin
        pal_idx   = {4'h0, data[3:0]};
        pal_first = 1'b1;
      end
      6'd17: begin
        ind_num = data[5:0];
        ind_inc = ~data[7];
      end
      6'd19: r19 = data;
      default: begin
        // Not held by the DUT
      end
    endcase
  endtask

  task automatic tick();
    @(posedge reset);
    #10;
  endtask

  task automatic check_val(input string name, input logic [7:0] got,
                           input logic [7:0] exp);
    assert (got === exp) else begin
      errors++;
      $display("Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
    end
  endtask

  // One-cycle request, returns 10 ns after the edge that sampled it
  task automatic cpu_access(input vdp_port_e p, input logic w, input logic [7:0] d);
    req  = 1'b1;
    wrt  = w;
    port = p;
    dbo  = d;
    tick();
    req = 1'b0;
    wrt = 1'b0;
  endtask

  task automatic check_regs();
    check_val("display_mode", 8'(display_mode), 8'(expected_mode(mode_act)));
    check_val("disp_on", 8'(disp_on), 8'(disp_act));
    check_val("hsync_int_en", 8'(hsync_int_en), 8'(r0[4]));
    check_val("vsync_int_en", 8'(vsync_int_en), 8'(r1[5]));
    check_val("sprite_size", 8'(sprite_size), 8'(r1[1]));
    check_val("sprite_zoom", 8'(sprite_zoom), 8'(r1[0]));
    check_val("sprite_off", 8'(sprite_off), 8'(r8[1]));
    check_val("col0_on", 8'(col0_on), 8'(r8[5]));
    check_val("pal_mode", 8'(pal_mode), 8'(r9[1]));
    check_val("y_dots", 8'(y_dots), 8'(r9[7]));
    check_val("frame_col", frame_col, r7);
    check_val("hint_line", hint_line, r19);
  endtask

  // --------------------------------------------------------------------------
  // Bus sequences
  // --------------------------------------------------------------------------
  task automatic reg_pair(input logic [5:0] num, input logic [7:0] data, input logic keep);
    logic [7:0] second;
    logic       hint;
    second = {keep, 1'($urandom), num};   // 0x on top would be a VRAM address
    hint   = keep && (num == 6'd19 || (num == 6'd0 && data[4]));
    cpu_access(port_ctrl, 1'b1, data);
    cpu_access(port_ctrl, 1'b1, second);
    check_val("clr_hsync_int", 8'(clr_hsync_int), 8'h00);
    tick();
    if (keep) begin
      model_write(num, data);
    end
    check_val("clr_hsync_int", 8'(clr_hsync_int), 8'(hint));
    check_regs();
  endtask

  task automatic indirect_write(input logic [7:0] data);
    logic hint;
    hint = (ind_num == 6'd19) || (ind_num == 6'd0 && data[4]);
    cpu_access(port_indirect, 1'b1, data);
    check_val("clr_hsync_int", 8'(clr_hsync_int), 8'h00);
    tick();
    if (ind_num != 6'd17) begin        // R17 refuses itself
      model_write(ind_num, data);
    end
    if (ind_inc) begin
      ind_num = ind_num + 6'd1;
    end
    check_val("clr_hsync_int", 8'(clr_hsync_int), 8'(hint));
    check_regs();
  endtask

  task automatic hsync_pulse();
    hsync = 1'b1;
    tick();
    hsync    = 1'b0;
    mode_act = {r0[3:1], r1[3], r1[4]};
    disp_act = r1[6];
    check_regs();
  endtask

  task automatic status_read();
    logic [7:0] exp;
    vsync_int_n = 1'($urandom);
    hsync_int_n = 1'($urandom);
    field       = 1'($urandom);
    exp = expected_status(r15);
    cpu_access(port_ctrl, 1'b0, 8'h00);
    check_val("dbi", dbi, exp);
    check_val("clr_vsync_int", 8'(clr_vsync_int), 8'(r15 == 4'd0));
    check_val("clr_hsync_int", 8'(clr_hsync_int), 8'(r15 == 4'd1));
    tick();
    check_val("clr_vsync_int", 8'(clr_vsync_int), 8'h00);
    check_val("clr_hsync_int", 8'(clr_hsync_int), 8'h00);
  endtask

  task automatic other_read(input vdp_port_e p);
    cpu_access(p, 1'b0, 8'h00);
    check_val("dbi", dbi, 8'hFF);
    check_val("clr_vsync_int", 8'(clr_vsync_int), 8'h00);
    check_val("clr_hsync_int", 8'(clr_hsync_int), 8'h00);
  endtask

  task automatic palette_byte(input logic [7:0] data);
    cpu_access(port_palette, 1'b1, data);
    if (pal_first) begin
      pal_red   = data[6:4];
      pal_blue  = data[2:0];
      pal_first = 1'b0;
    end else begin
      shadow_r[pal_idx] = {pal_red, 5'b00000};
      shadow_g[pal_idx] = {data[2:0], 5'b00000};
      shadow_b[pal_idx] = {pal_blue, 5'b00000};
      pal_idx   = pal_idx + 8'd1;
      pal_first = 1'b1;
    end
  endtask

  task automatic check_palette();
    for (int a = 0; a < 256; a++) begin
      palette_addr = 8'(a);
      tick();
      check_val("palette_r", palette_r, shadow_r[8'(a)]);
      check_val("palette_g", palette_g, shadow_g[8'(a)]);
      check_val("palette_b", palette_b, shadow_b[8'(a)]);
    end
  endtask

  // --------------------------------------------------------------------------
  // Test sequence
  // --------------------------------------------------------------------------
  initial begin
    logic [3:0] pick;
    logic [5:0] num;
    vdp_port_e  rd_port;
    void'($urandom(59));
    reset = 1'b0;
    clk21m = 1'b1;
    req = 1'b0;
    wrt = 1'b0;
    port = port_vram;
    dbo = 8'h00;
    hsync = 1'b0;
    vsync_int_n = 1'b1;
    hsync_int_n = 1'b1;
    field = 1'b0;
    palette_addr = 8'h00;
    {r0, r1, r7, r8, r9, r19} = '0;
    r15 = 4'h0;
    mode_act = 5'b00000;
    disp_act = 1'b0;
    ind_num = 6'd0;
    ind_inc = 1'b0;
    pal_idx = 8'h00;
    pal_first = 1'b1;
    pal_red = 3'b000;
    pal_blue = 3'b000;
    for (int i = 0; i < 256; i++) begin
      shadow_r[8'(i)] = (i < 16) ? PAL_INIT_R[4'(i)] : 8'h00;
      shadow_g[8'(i)] = (i < 16) ? PAL_INIT_G[4'(i)] : 8'h00;
      shadow_b[8'(i)] = (i < 16) ? PAL_INIT_B[4'(i)] : 8'h00;
    end
    repeat (3) @(posedge reset);
    #10;
    clk21m = 1'b0;

    // Reset state
    check_val("dbi", dbi, 8'h00);
    check_val("clr_vsync_int", 8'(clr_vsync_int), 8'h00);
    check_val("clr_hsync_int", 8'(clr_hsync_int), 8'h00);
    check_regs();
    check_palette();

    // Direct writes, mode bits wait for hsync
    for (int n = 0; n < 200; n++) begin
      pick = 4'($urandom % 12);
      num  = (pick < 9) ? HELD[pick] : 6'($urandom);
      reg_pair(num, 8'($urandom), ($urandom % 10) != 0);
      if ($urandom % 8 == 0) begin
        hsync_pulse();
      end
    end
    hsync_pulse();

    // Indirect writes
    reg_pair(6'd17, 8'h0F, 1'b1);            // From R15, auto-increment through R17
    repeat (6) indirect_write(8'($urandom));
    reg_pair(6'd17, 8'h87, 1'b1);            // R7 held
    repeat (4) indirect_write(8'($urandom));
    reg_pair(6'd17, 8'h91, 1'b1);            // Aimed at R17 itself
    indirect_write(8'h07);
    indirect_write(8'h5A);
    for (int n = 0; n < 10; n++) begin
      pick = 4'($urandom % 9);
      reg_pair(6'd17, {1'($urandom), 1'b0, HELD[pick]}, 1'b1);
      repeat (1 + $urandom % 6) indirect_write(8'($urandom));
    end

    // Palette
    reg_pair(6'd16, 8'($urandom), 1'b1);
    repeat (200) palette_byte(8'($urandom));
    repeat (2) tick();
    check_palette();

    // Status reads, R15 includes unsupported numbers
    for (int n = 0; n < 40; n++) begin
      reg_pair(6'd15, 8'($urandom), 1'b1);
      status_read();
      if ($urandom % 3 == 0) begin
        case ($urandom % 3)
          0:       rd_port = port_vram;
          1:       rd_port = port_palette;
          default: rd_port = port_indirect;
        endcase
        other_read(rd_port);
      end
    end
    repeat (5) begin
      cpu_access(port_ctrl, 1'b1, 8'($urandom));   // Orphan first byte
      status_read();
      reg_pair(6'd7, 8'($urandom), 1'b1);
    end

    // Line interrupt clear from register writes
    reg_pair(6'd19, 8'($urandom), 1'b1);
    reg_pair(6'd0, 8'h10 | 8'($urandom), 1'b1);
    reg_pair(6'd0, 8'hEF & 8'($urandom), 1'b1);
    reg_pair(6'd1, 8'($urandom), 1'b1);
    reg_pair(6'd9, 8'($urandom), 1'b1);
    hsync_pulse();

    repeat (2) tick();
    $display("Run finished with %0d errors", errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// ==== sources.f ====
vdp_pkg.sv
vdp_reg_bus_if.sv
vdp_port_decoder.sv
vdp_control_regs.sv
vdp_status_read.sv
vdp_palette.sv
vdp_register_top.sv
tb_vdp_register.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and scan the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f --top-module tb_vdp_register \
  -o tb_vdp_register

./obj_dir/tb_vdp_register | tee sim.log

if grep -q "=== FAIL ===" sim.log; then
  echo "Simulation reported failures, see sim.log"
  exit 1
fi

echo "Simulation finished without failures"
exit 0
